// File: filelist.f
noc_pkg.sv
router_pkg.sv
port_req_if.sv
xy_route_compute.sv
input_port.sv
crossbar_switch.sv
output_port.sv
mesh_router.sv
tb_mesh_router.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_mesh_router
FILELIST := filelist.f
BUILD    := obj_dir
PASS     := Simulation passed

BIN  := $(BUILD)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD)

// File: tb_mesh_router.sv
`timescale 1ns/1ps

module tb_mesh_router;

   localparam int          NP              = router_pkg::NUM_PORTS;
   localparam int          FW              = noc_pkg::FLIT_W;
   localparam int          NODE_X          = 1;
   localparam int          NODE_Y          = 1;
   localparam int          CLK_PERIOD      = 100;
   localparam int          RESET_CYCLES    = 4;
   localparam logic [31:0] SEED            = 32'h8285_fc61;
   localparam int          BURST_FLITS     = 4;
   localparam int          CONTEND_FLITS   = 12;
   localparam int          HOLD_CYCLES     = 24;
   localparam int          STALL_MIN       = 10;
   // 16 destinations per input, two blocked bursts, five contending inputs
   localparam int          TOTAL_FLITS     = NP * 16 + 2 * BURST_FLITS + NP * CONTEND_FLITS;
   localparam int          CYCLES_PER_FLIT = 40;

   logic                  clk;
   logic                  reset;
   logic [NP-1:0]         in_cyc;
   logic [NP-1:0]         in_stb;
   logic [NP-1:0][FW-1:0] in_dat;
   logic [NP-1:0]         in_ack;
   logic [NP-1:0]         out_cyc;
   logic [NP-1:0]         out_stb;
   logic [NP-1:0][FW-1:0] out_dat;
   logic [NP-1:0]         out_ack;

   // scoreboard, one queue per input and output pair
   logic [FW-1:0] sb_q [NP][NP][$];
   int            sent_count;
   int            delivered;
   logic          stim_started;
   logic          fair_on;
   logic [NP-1:0] out_hold;
   // deliveries of row input since last delivery of column input
   int            gap [NP][NP];
   // cycles since last in_ack per input
   int            ack_gap [NP];

   mesh_router #(
      .node_x (NODE_X),
      .node_y (NODE_Y)
   ) u_mesh_router (
      .clk     (clk),
      .reset   (reset),
      .in_cyc  (in_cyc),
      .in_stb  (in_stb),
      .in_dat  (in_dat),
      .in_ack  (in_ack),
      .out_cyc (out_cyc),
      .out_stb (out_stb),
      .out_dat (out_dat),
      .out_ack (out_ack)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reporting and reference model
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_mismatch(input string name, input int expv, input int actv);
      $display("CHECK FAILED %s: expected %0h actual %0h", name, expv, actv);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_error(input string msg);
      $display("ERROR %s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // XY rule with x first, east for larger x and south for larger y
   function automatic int xy_expected(input int dx, input int dy);
      if (dx > NODE_X) return router_pkg::IDX_EAST;
      if (dx < NODE_X) return router_pkg::IDX_WEST;
      if (dy > NODE_Y) return router_pkg::IDX_SOUTH;
      if (dy < NODE_Y) return router_pkg::IDX_NORTH;
      return router_pkg::IDX_LOCAL;
   endfunction

   // payload low bits carry the source input and the top bit is random
   function automatic logic [FW-1:0] make_flit(input int src, input int dx, input int dy);
      logic [FW-1:0] f;
      f = {1'($urandom_range(1, 0)), 3'(src), 2'(dx), 2'(dy)};
      return f;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // wishbone masters on the input links
   ////////////////////////////////////////////////////////////////////////////

   // called on a rising edge, returns on the edge that saw ack
   task automatic send_flit(input int p, input logic [FW-1:0] f);
      int exp_port;
      in_cyc[p] <= 1'b1;
      in_stb[p] <= 1'b1;
      in_dat[p] <= f;
      do begin
         @(posedge clk);
      end while (!in_ack[p]);
      exp_port = xy_expected(int'(f[3:2]), int'(f[1:0]));
      sb_q[p][exp_port].push_back(f);
      sent_count++;
   endtask

   task automatic release_link(input int p);
      in_cyc[p] <= 1'b0;
      in_stb[p] <= 1'b0;
   endtask

   // every mesh destination once
   task automatic drive_all_dests(input int p);
      @(posedge clk);
      for (int x = 0; x < noc_pkg::MESH_X; x++) begin
         for (int y = 0; y < noc_pkg::MESH_Y; y++) begin
            send_flit(p, make_flit(p, x, y));
         end
      end
      release_link(p);
   endtask

   // back to back flits to one destination
   task automatic drive_dest(input int p, input int dx, input int dy, input int n);
      @(posedge clk);
      for (int k = 0; k < n; k++) begin
         send_flit(p, make_flit(p, dx, dy));
      end
      release_link(p);
   endtask

   // one-cycle ack after 0 to 3 cycles, none while held
   task automatic respond(input int o);
      int delay;
      forever begin
         @(posedge clk);
         out_ack[o] <= 1'b0;
         if (out_stb[o] && !out_ack[o] && !out_hold[o]) begin
            delay = int'($urandom_range(3, 0));
            repeat (delay) @(posedge clk);
            out_ack[o] <= 1'b1;
         end
      end
   endtask

   initial begin
      out_ack = '0;
      fork
         respond(0);
         respond(1);
         respond(2);
         respond(3);
         respond(4);
      join
   end

   ////////////////////////////////////////////////////////////////////////////
   // scoreboard
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_delivery(input int o, input logic [FW-1:0] f);
      int            src;
      int            exp_port;
      logic [FW-1:0] front;
      src      = int'(f[6:4]);
      exp_port = xy_expected(int'(f[3:2]), int'(f[1:0]));
      assert (exp_port == o) else report_mismatch("routing", exp_port, o);
      assert (src < NP && sb_q[src][o].size() > 0)
         else report_error("flit left the router that no input had sent");
      front = sb_q[src][o].pop_front();
      // same input and output, oldest first
      assert (front == f) else report_mismatch("ordering", int'(front), int'(f));
      delivered++;
      if (fair_on) begin
         for (int j = 0; j < NP; j++) begin
            if (j != src) begin
               // idle inputs restart their count
               if (sb_q[j][o].size() == 0) begin
                  gap[src][j] = 0;
               end else begin
                  gap[src][j]++;
                  assert (gap[src][j] <= 1)
                     else report_mismatch("fairness", 1, gap[src][j]);
               end
               gap[j][src] = 0;
            end
         end
      end
   endtask

   always @(posedge clk) begin
      if (!reset) begin
         for (int o = 0; o < NP; o++) begin
            if (out_stb[o] && out_ack[o]) begin
               check_delivery(o, out_dat[o]);
            end
         end
      end
   end

   always @(posedge clk) begin
      for (int p = 0; p < NP; p++) begin
         if (reset || in_ack[p]) begin
            ack_gap[p] <= 0;
         end else begin
            ack_gap[p] <= ack_gap[p] + 1;
         end
      end
   end

   // blocked master still strobing, with no ack for a while
   task automatic check_stall(input int p);
      assert (in_stb[p])
         else report_error("input finished its burst while its output was held");
      assert (ack_gap[p] >= STALL_MIN)
         else report_mismatch("backpressure stall", STALL_MIN, ack_gap[p]);
   endtask

   task automatic wait_drained();
      while (delivered != sent_count) @(posedge clk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // link protocol assertions
   ////////////////////////////////////////////////////////////////////////////

   // quiet links until the first flit
   a_reset_state: assert property (@(posedge clk) disable iff (reset)
      !stim_started |-> (in_ack == '0 && out_cyc == '0 && out_stb == '0))
      else report_mismatch("reset state", 0, int'({in_ack, out_cyc, out_stb}));

   // ack is a single-cycle pulse
   a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
      (in_ack & $past(in_ack)) == '0)
      else report_mismatch("in_ack pulse", 0, int'(in_ack));

   // ack only answers a strobe
   a_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
      (in_ack & ~$past(in_cyc & in_stb)) == '0)
      else report_mismatch("in_ack after stb", 0, int'(in_ack));

   a_cyc_with_stb: assert property (@(posedge clk) disable iff (reset)
      (out_stb & ~out_cyc) == '0)
      else report_mismatch("out_cyc with out_stb", int'(out_stb), int'(out_cyc));

   // master holds the flit until acked
   for (genvar gp = 0; gp < NP; gp++) begin : g_hold
      a_out_hold: assert property (@(posedge clk) disable iff (reset)
         out_stb[gp] && !out_ack[gp] |=> out_stb[gp] && $stable(out_dat[gp]))
         else report_mismatch("backpressure hold", 1, int'(out_stb[gp]));
   end

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(SEED));
      reset        = 1'b1;
      in_cyc       = '0;
      in_stb       = '0;
      in_dat       = '0;
      out_hold     = '0;
      stim_started = 1'b0;
      fair_on      = 1'b0;
      sent_count   = 0;
      delivered    = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      // idle links after reset
      repeat (5) @(posedge clk);
      stim_started <= 1'b1;

      // all destinations from every input
      fork
         drive_all_dests(0);
         drive_all_dests(1);
         drive_all_dests(2);
         drive_all_dests(3);
         drive_all_dests(4);
      join
      wait_drained();

      // east output held, two inputs aimed at it
      out_hold[router_pkg::IDX_EAST] = 1'b1;
      fork
         drive_dest(router_pkg::IDX_LOCAL, 2, 1, BURST_FLITS);
         drive_dest(router_pkg::IDX_WEST, 3, 0, BURST_FLITS);
         begin
            repeat (HOLD_CYCLES) @(posedge clk);
            check_stall(router_pkg::IDX_LOCAL);
            check_stall(router_pkg::IDX_WEST);
            out_hold[router_pkg::IDX_EAST] = 1'b0;
         end
      join
      wait_drained();

      // five inputs fight for the local output
      for (int i = 0; i < NP; i++) begin
         for (int j = 0; j < NP; j++) begin
            gap[i][j] = 0;
         end
      end
      fair_on = 1'b1;
      fork
         drive_dest(0, NODE_X, NODE_Y, CONTEND_FLITS);
         drive_dest(1, NODE_X, NODE_Y, CONTEND_FLITS);
         drive_dest(2, NODE_X, NODE_Y, CONTEND_FLITS);
         drive_dest(3, NODE_X, NODE_Y, CONTEND_FLITS);
         drive_dest(4, NODE_X, NODE_Y, CONTEND_FLITS);
      join
      wait_drained();
      fair_on = 1'b0;
      repeat (5) @(posedge clk);

      if (delivered == TOTAL_FLITS && sent_count == TOTAL_FLITS) begin
         $display("Simulation passed");
         $finish;
      end else begin
         report_mismatch("flit count", TOTAL_FLITS, delivered);
      end
   end

   // run limit scales with traffic
   initial begin
      #(TOTAL_FLITS * CYCLES_PER_FLIT * CLK_PERIOD);
      report_error("timeout, flits were not all delivered in time");
   end

endmodule

// File: mesh_router.sv
`timescale 1ns/1ps

module mesh_router #(
   parameter int node_x = 1,
   parameter int node_y = 1
) (
   input  logic                                                 clk,
   input  logic                                                 reset,
   // links from the neighbors, local east north west south
   input  logic [router_pkg::NUM_PORTS-1:0]                     in_cyc,
   input  logic [router_pkg::NUM_PORTS-1:0]                     in_stb,
   input  logic [router_pkg::NUM_PORTS-1:0][noc_pkg::FLIT_W-1:0] in_dat,
   output logic [router_pkg::NUM_PORTS-1:0]                     in_ack,
   // links to the neighbors, same order
   output logic [router_pkg::NUM_PORTS-1:0]                     out_cyc,
   output logic [router_pkg::NUM_PORTS-1:0]                     out_stb,
   output logic [router_pkg::NUM_PORTS-1:0][noc_pkg::FLIT_W-1:0] out_dat,
   input  logic [router_pkg::NUM_PORTS-1:0]                     out_ack
);

   // crossbar to output registers
   logic [router_pkg::NUM_PORTS-1:0] out_load;
   logic [router_pkg::NUM_PORTS-1:0] out_empty;
   noc_pkg::flit_t                   out_flit [router_pkg::NUM_PORTS];

   // input FIFO heads to the crossbar
   port_req_if req [router_pkg::NUM_PORTS] ();

   ////////////////////////////////////////////////////////////////////////////
   // input side
   ////////////////////////////////////////////////////////////////////////////

   for (genvar gp = 0; gp < router_pkg::NUM_PORTS; gp++) begin : g_in
      input_port #(
         .node_x (node_x),
         .node_y (node_y)
      ) u_input_port (
         .clk   (clk),
         .reset (reset),
         .cyc   (in_cyc[gp]),
         .stb   (in_stb[gp]),
         .dat   (noc_pkg::flit_t'(in_dat[gp])),
         .ack   (in_ack[gp]),
         .req   (req[gp])
      );
   end

   // arbitration and switching
   crossbar_switch u_crossbar_switch (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .out_load  (out_load),
      .out_flit  (out_flit),
      .out_empty (out_empty)
   );

   ////////////////////////////////////////////////////////////////////////////
   // output side
   ////////////////////////////////////////////////////////////////////////////

   for (genvar gp = 0; gp < router_pkg::NUM_PORTS; gp++) begin : g_out
      output_port u_output_port (
         .clk   (clk),
         .reset (reset),
         .load  (out_load[gp]),
         .flit  (out_flit[gp]),
         .empty (out_empty[gp]),
         .cyc   (out_cyc[gp]),
         .stb   (out_stb[gp]),
         .dat   (out_dat[gp]),
         .ack   (out_ack[gp])
      );
   end

endmodule

// File: output_port.sv
`timescale 1ns/1ps

module output_port (
   input  logic           clk,
   input  logic           reset,
   input  logic           load,
   input  noc_pkg::flit_t flit,
   output logic           empty,
   output logic           cyc,
   output logic           stb,
   output noc_pkg::flit_t dat,
   input  logic           ack
);

   // holding register state
   typedef enum logic {
      op_idle,
      op_busy
   } op_state_e;

   op_state_e      state;
   noc_pkg::flit_t hold;

   // free now, or freed by ack at this edge
   assign empty = (state == op_idle) | ack;

   ////////////////////////////////////////////////////////////////////////////
   // wishbone classic master toward the next hop
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= op_idle;
      end else if (load) begin
         // a load may land on the same edge as the ack
         state <= op_busy;
      end else if (ack) begin
         state <= op_idle;
      end
   end

   // whole flit, destination and payload
   always_ff @(posedge clk) begin
      if (load) begin
         hold <= flit;
      end
   end

   // cyc and stb rise together and stay up until ack
   assign cyc = (state == op_busy);
   assign stb = (state == op_busy);
   assign dat = hold;

endmodule

// File: crossbar_switch.sv
`timescale 1ns/1ps

module crossbar_switch (
   input  logic                             clk,
   input  logic                             reset,
   port_req_if.switch                       req [router_pkg::NUM_PORTS],
   output logic [router_pkg::NUM_PORTS-1:0] out_load,
   output noc_pkg::flit_t                   out_flit [router_pkg::NUM_PORTS],
   input  logic [router_pkg::NUM_PORTS-1:0] out_empty
);

   localparam int NP = router_pkg::NUM_PORTS;

   // requests pulled out of the interface array
   logic [NP-1:0]                      in_valid;
   logic [NP-1:0][NP-1:0]              in_route;
   noc_pkg::flit_t                     in_flit [NP];
   logic [NP-1:0]                      in_grant;
   // per output, one-hot grant over inputs
   logic [NP-1:0][NP-1:0]              out_gnt;
   logic [router_pkg::RR_PTR_W-1:0]    win_idx  [NP];
   logic [router_pkg::RR_PTR_W-1:0]    last_ptr [NP];

   // interface arrays need constant indices
   for (genvar gi = 0; gi < NP; gi++) begin : g_unpack
      assign in_valid[gi]  = req[gi].valid;
      assign in_route[gi]  = req[gi].route;
      assign in_flit[gi]   = req[gi].flit;
      assign req[gi].grant = in_grant[gi];
   end

   ////////////////////////////////////////////////////////////////////////////
   // round-robin arbiters, one per output
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      int   idx;
      logic found;
      for (int o = 0; o < NP; o++) begin
         out_gnt[o] = '0;
         win_idx[o] = last_ptr[o];
         found      = 1'b0;
         // search starts just after the last winner
         for (int k = 1; k <= NP; k++) begin
            idx = (int'(last_ptr[o]) + k) % NP;
            if (!found && out_empty[o] && in_valid[idx] && in_route[idx][o]) begin
               out_gnt[o][idx] = 1'b1;
               win_idx[o]      = router_pkg::RR_PTR_W'(idx);
               found           = 1'b1;
            end
         end
      end
   end

   // one-hot routes, so at most one output grants each input
   always_comb begin
      for (int i = 0; i < NP; i++) begin
         in_grant[i] = 1'b0;
         for (int o = 0; o < NP; o++) begin
            in_grant[i] = in_grant[i] | out_gnt[o][i];
         end
      end
   end

   // pointer moves on the transfer edge only
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int o = 0; o < NP; o++) begin
            last_ptr[o] <= router_pkg::RR_PTR_W'(router_pkg::RR_START);
         end
      end else begin
         for (int o = 0; o < NP; o++) begin
            if (out_load[o]) begin
               last_ptr[o] <= win_idx[o];
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // flit multiplexers
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int o = 0; o < NP; o++) begin
         out_load[o] = |out_gnt[o];
         out_flit[o] = '0;
         for (int i = 0; i < NP; i++) begin
            if (out_gnt[o][i]) begin
               out_flit[o] = in_flit[i];
            end
         end
      end
   end

endmodule

// File: input_port.sv
`timescale 1ns/1ps

module input_port #(
   parameter int node_x = 1,
   parameter int node_y = 1
) (
   input  logic           clk,
   input  logic           reset,
   input  logic           cyc,
   input  logic           stb,
   input  noc_pkg::flit_t dat,
   output logic           ack,
   port_req_if.requester  req
);

   // circular flit buffer, no reset on storage
   noc_pkg::flit_t                   fifo_mem [noc_pkg::IN_BUF_DEPTH];
   logic [noc_pkg::BUF_PTR_W-1:0]    wr_ptr;
   logic [noc_pkg::BUF_PTR_W-1:0]    rd_ptr;
   logic [noc_pkg::BUF_CNT_W-1:0]    count;
   logic                             full;
   logic                             push;
   logic                             pop;
   logic [router_pkg::NUM_PORTS-1:0] head_route;

   assign full = (count == noc_pkg::BUF_CNT_W'(noc_pkg::IN_BUF_DEPTH));
   // flit lands on the edge that ends the ack cycle
   assign push = ack;
   // switch took the head flit
   assign pop  = req.valid & req.grant;

   ////////////////////////////////////////////////////////////////////////////
   // wishbone classic slave
   ////////////////////////////////////////////////////////////////////////////

   // one-cycle registered ack, only with room in the buffer
   always_ff @(posedge clk) begin
      if (reset) begin
         ack <= 1'b0;
      end else begin
         ack <= cyc & stb & ~ack & ~full;
      end
   end

   // storage write
   always_ff @(posedge clk) begin
      if (push) begin
         fifo_mem[wr_ptr] <= dat;
      end
   end

   // pointers and fill level
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == noc_pkg::BUF_PTR_W'(noc_pkg::IN_BUF_DEPTH - 1)) ?
                      '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == noc_pkg::BUF_PTR_W'(noc_pkg::IN_BUF_DEPTH - 1)) ?
                      '0 : rd_ptr + 1'b1;
         end
         count <= count + noc_pkg::BUF_CNT_W'(push) - noc_pkg::BUF_CNT_W'(pop);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // head flit routing and request
   ////////////////////////////////////////////////////////////////////////////

   xy_route_compute #(
      .node_x (node_x),
      .node_y (node_y)
   ) u_xy_route_compute (
      .dest_x   (fifo_mem[rd_ptr].dest_x),
      .dest_y   (fifo_mem[rd_ptr].dest_y),
      // switch works from the one-hot form only
      .out_port (),
      .route    (head_route)
   );

   assign req.valid = (count != '0);
   assign req.flit  = fifo_mem[rd_ptr];
   assign req.route = head_route;

endmodule

// File: xy_route_compute.sv
`timescale 1ns/1ps

module xy_route_compute #(
   parameter int node_x = 1,
   parameter int node_y = 1
) (
   input  logic [noc_pkg::COORD_W-1:0]   dest_x,
   input  logic [noc_pkg::COORD_W-1:0]   dest_y,
   output router_pkg::port_e             out_port,
   output logic [router_pkg::NUM_PORTS-1:0] route
);

   // own coordinates cut to coordinate width
   localparam logic [noc_pkg::COORD_W-1:0] own_x = noc_pkg::COORD_W'(node_x);
   localparam logic [noc_pkg::COORD_W-1:0] own_y = noc_pkg::COORD_W'(node_y);

   // one extra bit for the sign
   logic signed [noc_pkg::COORD_W:0] x_diff;
   logic signed [noc_pkg::COORD_W:0] y_diff;

   assign x_diff = $signed({1'b0, dest_x}) - $signed({1'b0, own_x});
   assign y_diff = $signed({1'b0, dest_y}) - $signed({1'b0, own_y});

   // x first, then y
   always_comb begin
      if (x_diff > 0) begin
         out_port = router_pkg::port_east;
      end else if (x_diff < 0) begin
         out_port = router_pkg::port_west;
      end else if (y_diff > 0) begin
         // y grows toward the south
         out_port = router_pkg::port_south;
      end else if (y_diff < 0) begin
         out_port = router_pkg::port_north;
      end else begin
         out_port = router_pkg::port_local;
      end
   end

   // port code to one-hot request
   always_comb begin
      route = '0;
      case (out_port)
         router_pkg::port_local: route[router_pkg::IDX_LOCAL] = 1'b1;
         router_pkg::port_east:  route[router_pkg::IDX_EAST]  = 1'b1;
         router_pkg::port_north: route[router_pkg::IDX_NORTH] = 1'b1;
         router_pkg::port_west:  route[router_pkg::IDX_WEST]  = 1'b1;
         router_pkg::port_south: route[router_pkg::IDX_SOUTH] = 1'b1;
         default:                route = '0;
      endcase
   end

endmodule

// File: port_req_if.sv
`timescale 1ns/1ps

interface port_req_if;

   // head flit of the input FIFO is waiting
   logic                             valid;
   // head flit itself
   noc_pkg::flit_t                   flit;
   // one-hot output request, indexed local east north west south
   logic [router_pkg::NUM_PORTS-1:0] route;
   // switch accepts the head flit this cycle
   logic                             grant;

   // input port side
   modport requester (
      output valid,
      output flit,
      output route,
      input  grant
   );

   // crossbar side
   modport switch (
      input  valid,
      input  flit,
      input  route,
      output grant
   );

endinterface

// File: router_pkg.sv
package router_pkg;

   // local plus four mesh neighbors
   localparam int NUM_PORTS = 5;

   // output port codes, numbered from 1
   typedef enum logic [2:0] {
      port_local = 3'd1,
      port_east  = 3'd2,
      port_north = 3'd3,
      port_west  = 3'd4,
      port_south = 3'd5
   } port_e;

   ////////////////////////////////////////////////////////////////////////////
   // index order of one-hot requests and link arrays
   ////////////////////////////////////////////////////////////////////////////

   localparam int IDX_LOCAL = 0;
   localparam int IDX_EAST  = 1;
   localparam int IDX_NORTH = 2;
   localparam int IDX_WEST  = 3;
   localparam int IDX_SOUTH = 4;

   // round-robin pointer, holds index of last granted input
   localparam int RR_PTR_W = $clog2(NUM_PORTS);
   // out of reset the search begins at input 0
   localparam int RR_START = NUM_PORTS - 1;

endpackage

// File: noc_pkg.sv
package noc_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // mesh geometry
   ////////////////////////////////////////////////////////////////////////////

   // 4x4 mesh of routers
   localparam int MESH_X = 4;
   localparam int MESH_Y = 4;

   // coordinate wide enough for the larger dimension
   localparam int COORD_W = $clog2((MESH_X > MESH_Y) ? MESH_X : MESH_Y);

   ////////////////////////////////////////////////////////////////////////////
   // flit layout
   ////////////////////////////////////////////////////////////////////////////

   localparam int PAYLOAD_W = 4;
   localparam int FLIT_W    = PAYLOAD_W + 2 * COORD_W;

   // single-flit packet, payload on top, destination in the low bits
   typedef struct packed {
      logic [PAYLOAD_W-1:0] payload;
      logic [COORD_W-1:0]   dest_x;
      logic [COORD_W-1:0]   dest_y;
   } flit_t;

   // per-input flit buffer
   localparam int IN_BUF_DEPTH = 2;
   localparam int BUF_PTR_W    = $clog2(IN_BUF_DEPTH);
   localparam int BUF_CNT_W    = $clog2(IN_BUF_DEPTH + 1);

endpackage
